/* decodeStage.sv */
`timescale 1ns/1ns
`default_nettype none

module decodeStage (
	input wire clk,
	input wire rst,
	input wire bubble,
	input wire mips32Isa::wordT instrId,
	input wire mips32Isa::wordT pc4Id,
	input wire mips32Pipe::fwdSelT fwdRsId,
	input wire mips32Pipe::fwdSelT fwdRtId,
	input wire mips32Isa::wordT aluResultEx,
	input wire mips32Isa::wordT aluResultMem,
	input wire wbWe,
	input wire mips32Isa::regIdxT wbAddr,
	input wire mips32Isa::wordT wbData,
	output logic redirect,
	output mips32Isa::wordT redirectPc,
	output mips32Isa::regIdxT rsId,
	output mips32Isa::regIdxT rtId,
	output logic usesRs,
	output logic usesRt,
	output logic isBranchId,
	output mips32Isa::regIdxT rsEx,
	output mips32Isa::regIdxT rtEx,
	output mips32Isa::regIdxT rdEx,
	output logic [4:0] shamtEx,
	output mips32Isa::wordT rsValEx,
	output mips32Isa::wordT rtValEx,
	output mips32Isa::wordT immEx,
	output mips32Isa::wordT pc4Ex,
	output mips32Pipe::aluOpT aluOpEx,
	output logic aluSrcImmEx,
	output mips32Pipe::regDstT regDstEx,
	output logic regWriteEx,
	output logic memReadEx,
	output logic memWriteEx,
	output mips32Pipe::wbSrcT wbSrcEx
);

	mips32Isa::opcodeT opcode;
	mips32Isa::functT funct;
	mips32Isa::wordT rsRaw, rtRaw, rsFwd, rtFwd, immId;
	mips32Pipe::aluOpT aluOp;
	mips32Pipe::regDstT regDst;
	mips32Pipe::wbSrcT wbSrc;
	mips32Pipe::nextPcT nextPc;
	logic aluSrcImm, regWrite, memRead, memWrite, zeroExt, branchNe;

	assign opcode = mips32Isa::opcodeT'(instrId[31:26]);
	assign funct = mips32Isa::functT'(instrId[5:0]);
	assign rsId = instrId[25:21];
	assign rtId = instrId[20:16];

	always_comb begin
		aluOp = mips32Pipe::ALU_ADD;
		aluSrcImm = 1'b0;
		regDst = mips32Pipe::DST_RT;
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		wbSrc = mips32Pipe::WB_ALU;
		nextPc = mips32Pipe::PC_SEQ;
		zeroExt = 1'b0;
		branchNe = 1'b0;
		usesRs = 1'b0;
		usesRt = 1'b0;
		isBranchId = 1'b0;
		case (opcode)
			mips32Isa::OP_RTYPE: begin
				regDst = mips32Pipe::DST_RD;
				regWrite = instrId != '0; // plain nop never retires
				usesRs = 1'b1;
				usesRt = 1'b1;
				case (funct)
					mips32Isa::F_ADDU: aluOp = mips32Pipe::ALU_ADD;
					mips32Isa::F_SUBU: aluOp = mips32Pipe::ALU_SUB;
					mips32Isa::F_AND: aluOp = mips32Pipe::ALU_AND;
					mips32Isa::F_OR: aluOp = mips32Pipe::ALU_OR;
					mips32Isa::F_XOR: aluOp = mips32Pipe::ALU_XOR;
					mips32Isa::F_NOR: aluOp = mips32Pipe::ALU_NOR;
					mips32Isa::F_SLT: aluOp = mips32Pipe::ALU_SLT;
					mips32Isa::F_SLL: begin
						aluOp = mips32Pipe::ALU_SLL;
						usesRs = 1'b0;
					end
					mips32Isa::F_SRL: begin
						aluOp = mips32Pipe::ALU_SRL;
						usesRs = 1'b0;
					end
					mips32Isa::F_JR: begin
						regWrite = 1'b0;
						usesRt = 1'b0;
						nextPc = mips32Pipe::PC_JR;
						isBranchId = 1'b1;
					end
					default: begin
						regWrite = 1'b0;
						usesRs = 1'b0;
						usesRt = 1'b0;
					end
				endcase
			end
			mips32Isa::OP_ADDIU, mips32Isa::OP_SLTI, mips32Isa::OP_ANDI,
			mips32Isa::OP_ORI: begin
				aluSrcImm = 1'b1;
				regWrite = 1'b1;
				usesRs = 1'b1;
				if (opcode == mips32Isa::OP_SLTI)
					aluOp = mips32Pipe::ALU_SLT;
				if (opcode == mips32Isa::OP_ANDI)
					aluOp = mips32Pipe::ALU_AND;
				if (opcode == mips32Isa::OP_ORI)
					aluOp = mips32Pipe::ALU_OR;
				zeroExt = opcode == mips32Isa::OP_ANDI || opcode == mips32Isa::OP_ORI;
			end
			mips32Isa::OP_LUI: begin
				aluOp = mips32Pipe::ALU_LUI;
				aluSrcImm = 1'b1;
				regWrite = 1'b1;
			end
			mips32Isa::OP_LW: begin
				aluSrcImm = 1'b1;
				regWrite = 1'b1;
				memRead = 1'b1;
				wbSrc = mips32Pipe::WB_MEM;
				usesRs = 1'b1;
			end
			mips32Isa::OP_SW: begin
				aluSrcImm = 1'b1;
				memWrite = 1'b1;
				usesRs = 1'b1;
				usesRt = 1'b1;
			end
			mips32Isa::OP_BEQ, mips32Isa::OP_BNE: begin
				nextPc = mips32Pipe::PC_BRANCH;
				branchNe = opcode == mips32Isa::OP_BNE;
				usesRs = 1'b1;
				usesRt = 1'b1;
				isBranchId = 1'b1;
			end
			mips32Isa::OP_J: nextPc = mips32Pipe::PC_JUMP;
			mips32Isa::OP_JAL: begin
				nextPc = mips32Pipe::PC_JUMP;
				regDst = mips32Pipe::DST_RA;
				regWrite = 1'b1;
				wbSrc = mips32Pipe::WB_PC4; // return address, no delay slot
			end
			default: ;
		endcase
	end

	assign immId = zeroExt ? {16'b0, instrId[15:0]} : {{16{instrId[15]}}, instrId[15:0]};

	registerFile regFile0 (
		.clk (clk),
		.rst (rst),
		.rsAddr (rsId),
		.rtAddr (rtId),
		.we (wbWe),
		.wAddr (wbAddr),
		.wData (wbData),
		.rsData (rsRaw),
		.rtData (rtRaw)
	);

	// comparator operands, EX result arrives the same cycle
	assign rsFwd = mips32Pipe::fwdMux(fwdRsId, rsRaw, aluResultEx, aluResultMem);
	assign rtFwd = mips32Pipe::fwdMux(fwdRtId, rtRaw, aluResultEx, aluResultMem);

	always_comb begin
		case (nextPc)
			mips32Pipe::PC_BRANCH: begin
				redirect = branchNe ? (rsFwd != rtFwd) : (rsFwd == rtFwd);
				redirectPc = pc4Id + {immId[29:0], 2'b00};
			end
			mips32Pipe::PC_JUMP: begin
				redirect = 1'b1;
				redirectPc = {pc4Id[31:28], instrId[25:0], 2'b00};
			end
			mips32Pipe::PC_JR: begin
				redirect = 1'b1;
				redirectPc = rsFwd;
			end
			default: begin
				redirect = 1'b0;
				redirectPc = pc4Id;
			end
		endcase
	end

	// ID/EX, a bubble only kills the write enables
	always_ff @(posedge clk) begin
		if (rst || bubble) begin
			regWriteEx <= 1'b0;
			memReadEx <= 1'b0;
			memWriteEx <= 1'b0;
		end else begin
			regWriteEx <= regWrite;
			memReadEx <= memRead;
			memWriteEx <= memWrite;
		end
		rsEx <= rsId;
		rtEx <= rtId;
		rdEx <= instrId[15:11];
		shamtEx <= instrId[10:6];
		rsValEx <= rsRaw;
		rtValEx <= rtRaw;
		immEx <= immId;
		pc4Ex <= pc4Id;
		aluOpEx <= aluOp;
		aluSrcImmEx <= aluSrcImm;
		regDstEx <= regDst;
		wbSrcEx <= wbSrc;
	end

endmodule

`default_nettype wire

/* executeStage.sv */
`timescale 1ns/1ns
`default_nettype none

module executeStage (
	input wire clk,
	input wire rst,
	input wire mips32Isa::regIdxT rtEx,
	input wire mips32Isa::regIdxT rdEx,
	input wire [4:0] shamtEx,
	input wire mips32Isa::wordT rsValEx,
	input wire mips32Isa::wordT rtValEx,
	input wire mips32Isa::wordT immEx,
	input wire mips32Isa::wordT pc4Ex,
	input wire mips32Pipe::aluOpT aluOpEx,
	input wire aluSrcImmEx,
	input wire mips32Pipe::regDstT regDstEx,
	input wire regWriteEx,
	input wire memReadEx,
	input wire memWriteEx,
	input wire mips32Pipe::wbSrcT wbSrcEx,
	input wire mips32Pipe::fwdSelT fwdRs,
	input wire mips32Pipe::fwdSelT fwdRt,
	input wire mips32Isa::wordT wbData,
	output mips32Isa::wordT aluResultEx,
	output mips32Isa::regIdxT destEx,
	output logic regWriteExOut,
	output logic memReadExOut,
	output mips32Isa::wordT aluResultMem,
	output mips32Isa::wordT storeDataMem,
	output mips32Isa::regIdxT destMem,
	output logic regWriteMem,
	output logic memReadMem,
	output logic memWriteMem,
	output mips32Pipe::wbSrcT wbSrcMem,
	output mips32Isa::wordT pc4Mem
);

	mips32Isa::wordT opA, rtOp, opB, aluOut;

	// aluResultMem is this stage's own EX/MEM register
	assign opA = mips32Pipe::fwdMux(fwdRs, rsValEx, aluResultMem, wbData);
	assign rtOp = mips32Pipe::fwdMux(fwdRt, rtValEx, aluResultMem, wbData);
	assign opB = aluSrcImmEx ? immEx : rtOp;

	always_comb begin
		case (aluOpEx)
			mips32Pipe::ALU_SUB: aluOut = opA - opB;
			mips32Pipe::ALU_AND: aluOut = opA & opB;
			mips32Pipe::ALU_OR: aluOut = opA | opB;
			mips32Pipe::ALU_XOR: aluOut = opA ^ opB;
			mips32Pipe::ALU_NOR: aluOut = ~(opA | opB);
			mips32Pipe::ALU_SLT: aluOut = {31'b0, $signed(opA) < $signed(opB)};
			mips32Pipe::ALU_SLL: aluOut = opB << shamtEx; // shifts act on rt
			mips32Pipe::ALU_SRL: aluOut = opB >> shamtEx;
			mips32Pipe::ALU_LUI: aluOut = {opB[15:0], 16'b0};
			default: aluOut = opA + opB;
		endcase
	end

	// jal carries its link value so forwarding sees it
	assign aluResultEx = (wbSrcEx == mips32Pipe::WB_PC4) ? pc4Ex : aluOut;

	always_comb begin
		case (regDstEx)
			mips32Pipe::DST_RD: destEx = rdEx;
			mips32Pipe::DST_RA: destEx = mips32Isa::REG_RA;
			default: destEx = rtEx;
		endcase
	end

	assign regWriteExOut = regWriteEx;
	assign memReadExOut = memReadEx;

	always_ff @(posedge clk) begin
		if (rst) begin
			regWriteMem <= 1'b0;
			memReadMem <= 1'b0;
			memWriteMem <= 1'b0;
		end else begin
			regWriteMem <= regWriteEx;
			memReadMem <= memReadEx;
			memWriteMem <= memWriteEx;
		end
		aluResultMem <= aluResultEx;
		storeDataMem <= rtOp; // forwarded rt for sw
		destMem <= destEx;
		wbSrcMem <= wbSrcEx;
		pc4Mem <= pc4Ex;
	end

endmodule

`default_nettype wire

/* fetchStage.sv */
`timescale 1ns/1ns
`default_nettype none
`include "mips32_defines.svh"

module fetchStage (
	input wire clk,
	input wire rst,
	input wire progWe,
	input wire [`IMEM_AW-1:0] progAddr,
	input wire mips32Isa::wordT progData,
	input wire stall,
	input wire flush,
	input wire redirect,
	input wire mips32Isa::wordT redirectPc,
	output mips32Isa::wordT instrId,
	output mips32Isa::wordT pc4Id
);

	mips32Isa::wordT imem [`IMEM_DEPTH];
	mips32Isa::wordT pc, pc4, instrIf;

	assign pc4 = pc + 32'd4;
	assign instrIf = imem[pc[`IMEM_AW+1:2]]; // word addressed

	// program port, only open while held in reset
	always_ff @(posedge clk) begin
		if (rst && progWe)
			imem[progAddr] <= progData;
	end

	always_ff @(posedge clk) begin
		if (rst)
			pc <= `RESET_PC;
		else if (!stall)
			pc <= redirect ? redirectPc : pc4;
	end

	// IF/ID, all zero word decodes as a nop
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			instrId <= '0;
			pc4Id <= '0;
		end else if (!stall) begin
			instrId <= instrIf;
			pc4Id <= pc4;
		end
	end

endmodule

`default_nettype wire

/* hazardForward.sv */
`timescale 1ns/1ns
`default_nettype none

module hazardForward (
	input wire mips32Isa::regIdxT rsId,
	input wire mips32Isa::regIdxT rtId,
	input wire usesRs,
	input wire usesRt,
	input wire isBranchId,
	input wire redirect,
	input wire mips32Isa::regIdxT rsEx,
	input wire mips32Isa::regIdxT rtEx,
	input wire mips32Isa::regIdxT destEx,
	input wire regWriteEx,
	input wire memReadEx,
	input wire mips32Isa::regIdxT destMem,
	input wire regWriteMem,
	input wire memReadMem,
	input wire mips32Isa::regIdxT wbAddr,
	input wire wbWe,
	output logic stall,
	output logic flush,
	output logic bubble,
	output mips32Pipe::fwdSelT fwdRsId,
	output mips32Pipe::fwdSelT fwdRtId,
	output mips32Pipe::fwdSelT fwdRs,
	output mips32Pipe::fwdSelT fwdRt
);

	logic loadUse, branchLoad;

	function automatic logic hit(mips32Isa::regIdxT src, mips32Isa::regIdxT dst);
		return dst != mips32Isa::REG_ZERO && src == dst;
	endfunction

	// the younger producer is checked first
	function automatic mips32Pipe::fwdSelT pick(mips32Isa::regIdxT src,
		logic nearWe, mips32Isa::regIdxT nearDst, logic farWe, mips32Isa::regIdxT farDst);
		if (nearWe && hit(src, nearDst))
			return mips32Pipe::FWD_MEM;
		if (farWe && hit(src, farDst))
			return mips32Pipe::FWD_WB;
		return mips32Pipe::FWD_NONE;
	endfunction

	assign loadUse = memReadEx &&
		((usesRs && hit(rsId, destEx)) || (usesRt && hit(rtId, destEx)));
	// compare in ID cannot use a load still in MEM
	assign branchLoad = isBranchId && memReadMem &&
		((usesRs && hit(rsId, destMem)) || (usesRt && hit(rtId, destMem)));

	assign stall = loadUse || branchLoad;
	assign bubble = stall;
	assign flush = redirect && !stall;

	assign fwdRsId = pick(rsId, regWriteEx, destEx, regWriteMem, destMem);
	assign fwdRtId = pick(rtId, regWriteEx, destEx, regWriteMem, destMem);
	assign fwdRs = pick(rsEx, regWriteMem, destMem, wbWe, wbAddr);
	assign fwdRt = pick(rtEx, regWriteMem, destMem, wbWe, wbAddr);

endmodule

`default_nettype wire

/* memoryStage.sv */
`timescale 1ns/1ns
`default_nettype none
`include "mips32_defines.svh"

module memoryStage (
	input wire clk,
	input wire rst,
	input wire mips32Isa::wordT aluResultMem,
	input wire mips32Isa::wordT storeDataMem,
	input wire mips32Isa::regIdxT destMem,
	input wire regWriteMem,
	input wire memReadMem,
	input wire memWriteMem,
	input wire mips32Pipe::wbSrcT wbSrcMem,
	input wire mips32Isa::wordT pc4Mem,
	output logic memWr,
	output mips32Isa::wordT memAddr,
	output mips32Isa::wordT memData,
	output logic wbWe,
	output mips32Isa::regIdxT wbAddr,
	output mips32Isa::wordT wbData
);

	mips32Isa::wordT dmem [`DMEM_DEPTH];
	mips32Isa::wordT loadData, aluResultWb, loadDataWb, pc4Wb;
	mips32Pipe::wbSrcT wbSrcWb;
	logic [`DMEM_AW-1:0] wordAddr;

	assign wordAddr = aluResultMem[`DMEM_AW+1:2]; // byte address to word index
	assign memWr = memWriteMem;
	assign memAddr = aluResultMem;
	assign memData = storeDataMem;

	always_ff @(posedge clk) begin
		if (memWriteMem)
			dmem[wordAddr] <= storeDataMem;
	end

	assign loadData = memReadMem ? dmem[wordAddr] : '0; // async read

	// MEM/WB
	always_ff @(posedge clk) begin
		if (rst)
			wbWe <= 1'b0;
		else
			wbWe <= regWriteMem;
		wbAddr <= destMem;
		wbSrcWb <= wbSrcMem;
		aluResultWb <= aluResultMem;
		loadDataWb <= loadData;
		pc4Wb <= pc4Mem;
	end

	always_comb begin
		case (wbSrcWb)
			mips32Pipe::WB_MEM: wbData = loadDataWb;
			mips32Pipe::WB_PC4: wbData = pc4Wb;
			default: wbData = aluResultWb;
		endcase
	end

endmodule

`default_nettype wire

/* mips32Isa.sv */
`default_nettype none

package mips32Isa;

	typedef logic [31:0] wordT;
	typedef logic [4:0] regIdxT;

	localparam regIdxT REG_ZERO = 5'd0;
	localparam regIdxT REG_RA = 5'd31; // jal link register

	// primary opcode field, bits 31:26
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J = 6'h02,
		OP_JAL = 6'h03,
		OP_BEQ = 6'h04,
		OP_BNE = 6'h05,
		OP_ADDIU = 6'h09,
		OP_SLTI = 6'h0a,
		OP_ANDI = 6'h0c,
		OP_ORI = 6'h0d,
		OP_LUI = 6'h0f,
		OP_LW = 6'h23,
		OP_SW = 6'h2b
	} opcodeT;

	// funct field of R-type, bits 5:0
	typedef enum logic [5:0] {
		F_SLL = 6'h00,
		F_SRL = 6'h02,
		F_JR = 6'h08,
		F_ADDU = 6'h21,
		F_SUBU = 6'h23,
		F_AND = 6'h24,
		F_OR = 6'h25,
		F_XOR = 6'h26,
		F_NOR = 6'h27,
		F_SLT = 6'h2a
	} functT;

endpackage

`default_nettype wire

/* mips32Pipe.sv */
`default_nettype none

package mips32Pipe;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
		ALU_NOR, ALU_SLT, ALU_SLL, ALU_SRL, ALU_LUI
	} aluOpT;

	// in decode, FWD_MEM means EX and FWD_WB means MEM
	typedef enum logic [1:0] {FWD_NONE = 2'd0, FWD_MEM = 2'd1, FWD_WB = 2'd2} fwdSelT;

	typedef enum logic [1:0] {DST_RD, DST_RT, DST_RA} regDstT;

	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wbSrcT;

	typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JUMP, PC_JR} nextPcT;

	// operand pick shared by decode and execute
	function automatic logic [31:0] fwdMux(fwdSelT sel, logic [31:0] own,
		logic [31:0] nearer, logic [31:0] farther);
		case (sel)
			FWD_MEM: return nearer;
			FWD_WB: return farther;
			default: return own;
		endcase
	endfunction

endpackage

`default_nettype wire

/* mips32Top.f */
+incdir+.
mips32Isa.sv
mips32Pipe.sv
registerFile.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
hazardForward.sv
mips32Top.sv
mips32Top_tb.sv

/* mips32Top.sv */
`timescale 1ns/1ns
`default_nettype none
`include "mips32_defines.svh"

module mips32Top (
	input wire clk,
	input wire rst,
	input wire progWe,
	input wire [`IMEM_AW-1:0] progAddr,
	input wire mips32Isa::wordT progData,
	output logic wbWe,
	output mips32Isa::regIdxT wbAddr,
	output mips32Isa::wordT wbData,
	output logic memWr,
	output mips32Isa::wordT memAddr,
	output mips32Isa::wordT memData,
	output logic branchTaken
);

	logic stall, flush, bubble, redirect;
	mips32Isa::wordT redirectPc, instrId, pc4Id;
	// ID side
	mips32Isa::regIdxT rsId, rtId;
	logic usesRs, usesRt, isBranchId;
	mips32Pipe::fwdSelT fwdRsId, fwdRtId, fwdRs, fwdRt;
	// ID/EX
	mips32Isa::regIdxT rsEx, rtEx, rdEx, destEx;
	logic [4:0] shamtEx;
	mips32Isa::wordT rsValEx, rtValEx, immEx, pc4Ex, aluResultEx;
	mips32Pipe::aluOpT aluOpEx;
	mips32Pipe::regDstT regDstEx;
	mips32Pipe::wbSrcT wbSrcEx, wbSrcMem;
	logic aluSrcImmEx, regWriteEx, memReadEx, memWriteEx;
	logic regWriteExOut, memReadExOut;
	// EX/MEM
	mips32Isa::wordT aluResultMem, storeDataMem, pc4Mem;
	mips32Isa::regIdxT destMem;
	logic regWriteMem, memReadMem, memWriteMem;

	assign branchTaken = flush; // redirect that is not held by a stall

	fetchStage fetch0 (
		.clk (clk), .rst (rst),
		.progWe (progWe), .progAddr (progAddr), .progData (progData),
		.stall (stall), .flush (flush),
		.redirect (redirect), .redirectPc (redirectPc),
		.instrId (instrId), .pc4Id (pc4Id)
	);

	decodeStage decode0 (
		.clk (clk), .rst (rst), .bubble (bubble),
		.instrId (instrId), .pc4Id (pc4Id),
		.fwdRsId (fwdRsId), .fwdRtId (fwdRtId),
		.aluResultEx (aluResultEx), .aluResultMem (aluResultMem),
		.wbWe (wbWe), .wbAddr (wbAddr), .wbData (wbData),
		.redirect (redirect), .redirectPc (redirectPc),
		.rsId (rsId), .rtId (rtId), .usesRs (usesRs), .usesRt (usesRt),
		.isBranchId (isBranchId),
		.rsEx (rsEx), .rtEx (rtEx), .rdEx (rdEx), .shamtEx (shamtEx),
		.rsValEx (rsValEx), .rtValEx (rtValEx), .immEx (immEx), .pc4Ex (pc4Ex),
		.aluOpEx (aluOpEx), .aluSrcImmEx (aluSrcImmEx), .regDstEx (regDstEx),
		.regWriteEx (regWriteEx), .memReadEx (memReadEx), .memWriteEx (memWriteEx),
		.wbSrcEx (wbSrcEx)
	);

	executeStage execute0 (
		.clk (clk), .rst (rst),
		.rtEx (rtEx), .rdEx (rdEx), .shamtEx (shamtEx),
		.rsValEx (rsValEx), .rtValEx (rtValEx), .immEx (immEx), .pc4Ex (pc4Ex),
		.aluOpEx (aluOpEx), .aluSrcImmEx (aluSrcImmEx), .regDstEx (regDstEx),
		.regWriteEx (regWriteEx), .memReadEx (memReadEx), .memWriteEx (memWriteEx),
		.wbSrcEx (wbSrcEx),
		.fwdRs (fwdRs), .fwdRt (fwdRt), .wbData (wbData),
		.aluResultEx (aluResultEx), .destEx (destEx),
		.regWriteExOut (regWriteExOut), .memReadExOut (memReadExOut),
		.aluResultMem (aluResultMem), .storeDataMem (storeDataMem), .destMem (destMem),
		.regWriteMem (regWriteMem), .memReadMem (memReadMem), .memWriteMem (memWriteMem),
		.wbSrcMem (wbSrcMem), .pc4Mem (pc4Mem)
	);

	memoryStage memory0 (
		.clk (clk), .rst (rst),
		.aluResultMem (aluResultMem), .storeDataMem (storeDataMem), .destMem (destMem),
		.regWriteMem (regWriteMem), .memReadMem (memReadMem), .memWriteMem (memWriteMem),
		.wbSrcMem (wbSrcMem), .pc4Mem (pc4Mem),
		.memWr (memWr), .memAddr (memAddr), .memData (memData),
		.wbWe (wbWe), .wbAddr (wbAddr), .wbData (wbData)
	);

	hazardForward hazard0 (
		.rsId (rsId), .rtId (rtId), .usesRs (usesRs), .usesRt (usesRt),
		.isBranchId (isBranchId), .redirect (redirect),
		.rsEx (rsEx), .rtEx (rtEx),
		.destEx (destEx), .regWriteEx (regWriteExOut), .memReadEx (memReadExOut),
		.destMem (destMem), .regWriteMem (regWriteMem), .memReadMem (memReadMem),
		.wbAddr (wbAddr), .wbWe (wbWe),
		.stall (stall), .flush (flush), .bubble (bubble),
		.fwdRsId (fwdRsId), .fwdRtId (fwdRtId), .fwdRs (fwdRs), .fwdRt (fwdRt)
	);

endmodule

`default_nettype wire

/* mips32Top_tb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "mips32_defines.svh"

module mips32Top_tb;

	localparam logic [31:0] HALT = 32'h1000_ffff; // beq $0,$0,-1
	localparam int TIMEOUT = 400;

	logic clk, rst, progWe;
	logic [`IMEM_AW-1:0] progAddr;
	mips32Isa::wordT progData;
	logic wbWe, memWr, branchTaken;
	mips32Isa::regIdxT wbAddr;
	mips32Isa::wordT wbData, memAddr, memData;

	logic [31:0] prog [$];
	logic [31:0] gotAddr [$], gotData [$], stAddr [$], stData [$];
	int takenAt [$]; // writes seen when each branch was taken
	logic [31:0] expAddr [$], expData [$], expStAddr [$], expStData [$];
	int expTaken;
	logic [31:0] modelRegs [32];
	logic [31:0] modelMem [256];
	logic [31:0] lfsr;
	int checks, errors;

	mips32Top dut0 (
		.clk (clk), .rst (rst),
		.progWe (progWe), .progAddr (progAddr), .progData (progData),
		.wbWe (wbWe), .wbAddr (wbAddr), .wbData (wbData),
		.memWr (memWr), .memAddr (memAddr), .memData (memData),
		.branchTaken (branchTaken)
	);

	always #2 clk = ~clk;

	// mid-cycle sampling, all outputs settled
	always @(negedge clk) begin
		if (wbWe === 1'b1) begin
			gotAddr.push_back({27'b0, wbAddr});
			gotData.push_back(wbData);
		end
		if (memWr === 1'b1) begin
			stAddr.push_back(memAddr);
			stData.push_back(memData);
		end
		if (branchTaken === 1'b1)
			takenAt.push_back(gotAddr.size());
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrBits(int n);
		logic [31:0] v;
		logic fb;
		int k;
		v = '0;
		for (k = 0; k < n; k++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic logic [31:0] encR(mips32Isa::functT f, int rs, int rt, int rd, int sh);
		return {6'h00, rs[4:0], rt[4:0], rd[4:0], sh[4:0], f};
	endfunction

	function automatic logic [31:0] encI(mips32Isa::opcodeT op, int rs, int rt,
		logic [15:0] imm);
		return {op, rs[4:0], rt[4:0], imm};
	endfunction

	function automatic logic [31:0] encJ(mips32Isa::opcodeT op, int wordIdx);
		return {op, wordIdx[25:0]};
	endfunction

	task automatic checkValue(input logic [31:0] got, input logic [31:0] exp,
		input string msg);
		checks++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s (got %h, expected %h)", $time, msg, got, exp);
			errors++;
		end
	endtask

	task automatic appendWord(input logic [31:0] w);
		prog.push_back(w);
	endtask

	// padding keeps the halt loop clear of the last retirement
	task automatic appendHalt();
		repeat (3) prog.push_back(32'h0);
		prog.push_back(HALT);
	endtask

	task automatic clearRecords();
		gotAddr.delete();
		gotData.delete();
		stAddr.delete();
		stData.delete();
		takenAt.delete();
	endtask

	task automatic modelRetire(input logic [4:0] d, input logic [31:0] v);
		expAddr.push_back({27'b0, d});
		expData.push_back(v);
		if (d != 5'd0)
			modelRegs[d] = v;
	endtask

	// sequential MIPS semantics, no delay slot
	task automatic runReferenceModel();
		logic [31:0] pc, ins, nxt, a, b, se, ze, ea;
		int idx, steps;
		expAddr.delete();
		expData.delete();
		expStAddr.delete();
		expStData.delete();
		expTaken = 0;
		foreach (modelRegs[i]) modelRegs[i] = '0;
		foreach (modelMem[i]) modelMem[i] = '0;
		pc = `RESET_PC;
		for (steps = 0; steps < 1000; steps++) begin
			idx = int'(pc >> 2);
			if (idx >= prog.size()) begin
				$display("reference model ran past the end of the program");
				errors++;
				break;
			end
			ins = prog[idx];
			if (ins == HALT)
				break;
			a = modelRegs[ins[25:21]];
			b = modelRegs[ins[20:16]];
			se = {{16{ins[15]}}, ins[15:0]};
			ze = {16'b0, ins[15:0]};
			ea = a + se;
			nxt = pc + 32'd4;
			case (ins[31:26])
				mips32Isa::OP_RTYPE: begin
					if (ins != 32'h0) begin // nop retires nothing
						case (ins[5:0])
							mips32Isa::F_ADDU: modelRetire(ins[15:11], a + b);
							mips32Isa::F_SUBU: modelRetire(ins[15:11], a - b);
							mips32Isa::F_AND: modelRetire(ins[15:11], a & b);
							mips32Isa::F_OR: modelRetire(ins[15:11], a | b);
							mips32Isa::F_XOR: modelRetire(ins[15:11], a ^ b);
							mips32Isa::F_NOR: modelRetire(ins[15:11], ~(a | b));
							mips32Isa::F_SLT:
								modelRetire(ins[15:11], {31'b0, $signed(a) < $signed(b)});
							mips32Isa::F_SLL: modelRetire(ins[15:11], b << ins[10:6]);
							mips32Isa::F_SRL: modelRetire(ins[15:11], b >> ins[10:6]);
							mips32Isa::F_JR: begin
								nxt = a;
								expTaken++;
							end
							default: ;
						endcase
					end
				end
				mips32Isa::OP_ADDIU: modelRetire(ins[20:16], a + se);
				mips32Isa::OP_SLTI: modelRetire(ins[20:16], {31'b0, $signed(a) < $signed(se)});
				mips32Isa::OP_ANDI: modelRetire(ins[20:16], a & ze);
				mips32Isa::OP_ORI: modelRetire(ins[20:16], a | ze);
				mips32Isa::OP_LUI: modelRetire(ins[20:16], {ins[15:0], 16'b0});
				mips32Isa::OP_LW: modelRetire(ins[20:16], modelMem[ea[9:2]]);
				mips32Isa::OP_SW: begin
					modelMem[ea[9:2]] = b;
					expStAddr.push_back(ea);
					expStData.push_back(b);
				end
				mips32Isa::OP_BEQ, mips32Isa::OP_BNE: begin
					if ((a == b) == (ins[31:26] == mips32Isa::OP_BEQ)) begin
						nxt = pc + 32'd4 + {se[29:0], 2'b00};
						expTaken++;
					end
				end
				mips32Isa::OP_J, mips32Isa::OP_JAL: begin
					if (ins[31:26] == mips32Isa::OP_JAL)
						modelRetire(5'd31, pc + 32'd4);
					nxt = {nxt[31:28], ins[25:0], 2'b00};
					expTaken++;
				end
				default: ;
			endcase
			pc = nxt;
		end
		if (steps == 1000) begin
			$display("reference model never reached the halt loop");
			errors++;
		end
	endtask

	// program goes in while rst is high, at least 4 cycles
	task automatic loadProgram();
		int n, i;
		n = (prog.size() > 4) ? prog.size() : 4;
		rst = 1'b1;
		for (i = 0; i < n; i++) begin
			progWe = i < prog.size();
			progAddr = i[7:0];
			progData = (i < prog.size()) ? prog[i] : 32'h0;
			@(posedge clk);
			#1;
		end
		progWe = 1'b0;
		rst = 1'b0;
		clearRecords();
	endtask

	task automatic waitForWrites(input int n, input string name);
		int cyc;
		cyc = 0;
		while (gotAddr.size() < n && cyc < TIMEOUT) begin
			@(posedge clk);
			#1;
			cyc++;
		end
		if (gotAddr.size() < n) begin
			$display("%s: timed out with %0d of %0d register writes seen", name,
				gotAddr.size(), n);
			errors++;
		end
	endtask

	// halt loop taken twice, nothing older still in flight
	task automatic waitForHalt(input int nWr, input string name);
		int cyc, seen;
		cyc = 0;
		seen = 0;
		while (seen < 2 && cyc < TIMEOUT) begin
			@(posedge clk);
			#1;
			cyc++;
			seen = 0;
			foreach (takenAt[j])
				if (takenAt[j] >= nWr)
					seen++;
		end
		if (seen < 2) begin
			$display("%s: program never reached its halt loop", name);
			errors++;
		end
	endtask

	task automatic runAndCompare(input string name);
		int nWr, taken, i;
		runReferenceModel();
		nWr = expAddr.size();
		loadProgram();
		waitForWrites(nWr, name);
		waitForHalt(nWr, name);
		checkValue(gotAddr.size(), nWr, {name, ": write count"});
		for (i = 0; i < nWr && i < gotAddr.size(); i++) begin
			checkValue(gotAddr[i], expAddr[i], $sformatf("%s: write %0d address", name, i));
			checkValue(gotData[i], expData[i], $sformatf("%s: write %0d data", name, i));
		end
		checkValue(stAddr.size(), expStAddr.size(), {name, ": store count"});
		for (i = 0; i < expStAddr.size() && i < stAddr.size(); i++) begin
			checkValue(stAddr[i], expStAddr[i], $sformatf("%s: store %0d address", name, i));
			checkValue(stData[i], expStData[i], $sformatf("%s: store %0d data", name, i));
		end
		taken = 0;
		foreach (takenAt[j])
			if (takenAt[j] < nWr)
				taken++;
		checkValue(taken, expTaken, {name, ": taken branches"});
	endtask

	// each result feeds the next, MEM and WB forwarding
	task automatic aluChain();
		logic [31:0] v1, v2, v3, sh;
		v1 = lfsrBits(16);
		v2 = lfsrBits(16);
		v3 = lfsrBits(16);
		sh = lfsrBits(5);
		prog.delete();
		appendWord(encI(mips32Isa::OP_LUI, 0, 1, v1[15:0]));
		appendWord(encI(mips32Isa::OP_ORI, 1, 1, v2[15:0]));
		appendWord(encI(mips32Isa::OP_ADDIU, 0, 2, v3[15:0]));
		appendWord(encR(mips32Isa::F_ADDU, 1, 2, 3, 0));
		appendWord(encR(mips32Isa::F_SUBU, 3, 1, 4, 0));
		appendWord(encR(mips32Isa::F_XOR, 4, 3, 5, 0));
		appendWord(encR(mips32Isa::F_NOR, 5, 2, 6, 0));
		appendWord(encR(mips32Isa::F_SLT, 6, 1, 7, 0));
		appendWord(encR(mips32Isa::F_SLL, 0, 5, 8, int'(sh)));
		appendWord(encR(mips32Isa::F_SRL, 0, 8, 9, int'(sh)));
		appendWord(encR(mips32Isa::F_AND, 9, 6, 10, 0));
		appendWord(encR(mips32Isa::F_OR, 10, 4, 11, 0));
		appendWord(encI(mips32Isa::OP_SLTI, 11, 12, v3[15:0]));
		appendWord(encI(mips32Isa::OP_ANDI, 5, 13, v2[15:0]));
		appendHalt();
		runAndCompare("alu chain");
	endtask

	task automatic loadUse();
		logic [31:0] hi, lo, off;
		hi = lfsrBits(16);
		lo = lfsrBits(16);
		off = lfsrBits(6) << 2;
		prog.delete();
		appendWord(encI(mips32Isa::OP_LUI, 0, 2, hi[15:0]));
		appendWord(encI(mips32Isa::OP_ORI, 2, 2, lo[15:0]));
		appendWord(encI(mips32Isa::OP_ADDIU, 0, 1, 16'h0100));
		appendWord(encI(mips32Isa::OP_SW, 1, 2, off[15:0]));
		appendWord(encI(mips32Isa::OP_LW, 1, 3, off[15:0]));
		appendWord(encR(mips32Isa::F_ADDU, 3, 2, 4, 0)); // one stall
		appendWord(encI(mips32Isa::OP_LW, 1, 5, off[15:0]));
		appendWord(encI(mips32Isa::OP_SW, 1, 5, off[15:0] + 16'd4)); // load into store data
		appendWord(encI(mips32Isa::OP_LW, 1, 6, off[15:0] + 16'd4));
		appendWord(encI(mips32Isa::OP_ADDIU, 6, 7, 16'd1));
		appendHalt();
		runAndCompare("load-use");
	endtask

	task automatic branches();
		logic [31:0] a;
		a = lfsrBits(16);
		prog.delete();
		appendWord(encI(mips32Isa::OP_ADDIU, 0, 1, a[15:0]));
		appendWord(encI(mips32Isa::OP_ADDIU, 0, 2, a[15:0]));
		appendWord(encI(mips32Isa::OP_BEQ, 1, 2, 16'd1)); // taken, $2 still in EX
		appendWord(encI(mips32Isa::OP_ADDIU, 0, 3, 16'h0111));
		appendWord(encI(mips32Isa::OP_BNE, 1, 2, 16'd1)); // falls through
		appendWord(encI(mips32Isa::OP_ADDIU, 0, 4, 16'h0222));
		appendWord(encI(mips32Isa::OP_ADDIU, 1, 5, 16'd1));
		appendWord(encI(mips32Isa::OP_BNE, 5, 1, 16'd2));
		appendWord(encI(mips32Isa::OP_ADDIU, 0, 6, 16'h0333));
		appendWord(encI(mips32Isa::OP_ADDIU, 0, 7, 16'h0444));
		appendWord(encI(mips32Isa::OP_BEQ, 5, 1, 16'd1));
		appendWord(encI(mips32Isa::OP_SW, 0, 5, 16'h0080));
		appendWord(encI(mips32Isa::OP_LW, 0, 8, 16'h0080));
		appendWord(encI(mips32Isa::OP_BEQ, 8, 5, 16'd1)); // branch on load
		appendWord(encI(mips32Isa::OP_ADDIU, 0, 9, 16'h0555));
		appendWord(encI(mips32Isa::OP_ADDIU, 8, 10, 16'd2));
		appendHalt();
		runAndCompare("branches");
	endtask

	task automatic jumps();
		logic [31:0] r;
		r = lfsrBits(16);
		prog.delete();
		appendWord(encI(mips32Isa::OP_ADDIU, 0, 1, r[15:0]));
		appendWord(encJ(mips32Isa::OP_JAL, 5));
		appendWord(encI(mips32Isa::OP_ADDIU, 1, 2, 16'd3)); // return point
		appendWord(encJ(mips32Isa::OP_J, 7));
		appendWord(encI(mips32Isa::OP_ADDIU, 0, 3, 16'h0666));
		appendWord(encI(mips32Isa::OP_ADDIU, 1, 4, 16'd5)); // subroutine
		appendWord(encR(mips32Isa::F_JR, 31, 0, 0, 0));
		appendWord(encI(mips32Isa::OP_ADDIU, 31, 5, 16'd0));
		appendHalt();
		runAndCompare("jumps");
	endtask

	task automatic registerZero();
		logic [31:0] r;
		r = lfsrBits(16);
		prog.delete();
		appendWord(encI(mips32Isa::OP_ADDIU, 0, 0, r[15:0]));
		appendWord(encR(mips32Isa::F_ADDU, 0, 0, 1, 0)); // must not see the write above
		appendWord(encI(mips32Isa::OP_LUI, 0, 0, r[15:0]));
		appendWord(encI(mips32Isa::OP_ADDIU, 0, 2, r[15:0]));
		appendWord(encR(mips32Isa::F_SLL, 0, 2, 0, 4));
		appendWord(encR(mips32Isa::F_SUBU, 2, 0, 3, 0));
		appendWord(encR(mips32Isa::F_ADDU, 0, 3, 4, 0));
		appendHalt();
		runAndCompare("register zero");
	endtask

	task automatic midRunReset();
		int cyc;
		prog.delete();
		appendWord(encI(mips32Isa::OP_ADDIU, 0, 1, 16'd5));
		appendWord(encI(mips32Isa::OP_ADDIU, 1, 1, 16'd1));
		appendWord(encI(mips32Isa::OP_SW, 0, 1, 16'h0040));
		appendWord(encI(mips32Isa::OP_BEQ, 0, 0, 16'hfffd)); // endless loop
		loadProgram();
		waitForWrites(3, "reset loop");
		if (gotAddr.size() >= 3 && stAddr.size() >= 1) begin
			checkValue(gotData[0], 32'd5, "reset loop: first write");
			checkValue(gotData[2], 32'd7, "reset loop: third write");
			checkValue(stAddr[0], 32'h40, "reset loop: store address");
			checkValue(stData[0], 32'd6, "reset loop: store data");
		end else begin
			$display("reset loop: register writes or the store never showed up");
			errors++;
		end
		rst = 1'b1;
		@(posedge clk);
		#1;
		clearRecords();
		for (cyc = 0; cyc < 4; cyc++) begin
			@(posedge clk);
			#1;
		end
		checkValue(gotAddr.size(), 0, "register writes while in reset");
		checkValue(stAddr.size(), 0, "stores while in reset");
		prog.delete();
		appendWord(encI(mips32Isa::OP_ADDIU, 0, 1, 16'h0123));
		appendWord(encR(mips32Isa::F_ADDU, 1, 1, 2, 0));
		appendWord(encI(mips32Isa::OP_SW, 0, 2, 16'h0044));
		appendWord(encI(mips32Isa::OP_ADDIU, 2, 3, 16'hffff));
		appendHalt();
		runAndCompare("reload after reset");
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;
		lfsr = 32'h5a97b09c;
		checks = 0;
		errors = 0;
		@(posedge clk);
		#1;
		aluChain();
		loadUse();
		branches();
		jumps();
		registerZero();
		midRunReset();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* mips32_defines.svh */
`ifndef MIPS32_DEFINES_SVH
`define MIPS32_DEFINES_SVH

// memory sizes in 32-bit words
`define IMEM_DEPTH 256
`define DMEM_DEPTH 256

// word address widths
`define IMEM_AW 8
`define DMEM_AW 8

`define RESET_PC 32'h0000_0000

`endif

/* registerFile.sv */
`timescale 1ns/1ns
`default_nettype none

module registerFile (
	input wire clk,
	input wire rst,
	input wire mips32Isa::regIdxT rsAddr,
	input wire mips32Isa::regIdxT rtAddr,
	input wire we,
	input wire mips32Isa::regIdxT wAddr,
	input wire mips32Isa::wordT wData,
	output mips32Isa::wordT rsData,
	output mips32Isa::wordT rtData
);

	mips32Isa::wordT regs [1:31]; // no storage behind $0

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (we && wAddr != mips32Isa::REG_ZERO) begin
			regs[wAddr] <= wData;
		end
	end

	// write in the same cycle wins over the stored value
	assign rsData = (rsAddr == mips32Isa::REG_ZERO) ? '0 :
		(we && wAddr == rsAddr) ? wData : regs[rsAddr];
	assign rtData = (rtAddr == mips32Isa::REG_ZERO) ? '0 :
		(we && wAddr == rtAddr) ? wData : regs[rtAddr];

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module mips32Top_tb -f mips32Top.f &&
./obj_dir/Vmips32Top_tb | tee /dev/stderr | grep -qx "All tests passed" ||
{ echo "simulation failed"; exit 1; }
